// ==== logic/rv_pkg.sv ====
// Shared types and constants for the RV32I single-cycle core
// Only the RV32I base opcodes are listed, no CSR or compressed encodings

`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPCODE_LUI      = 7'b0110111,
    OPCODE_AUIPC    = 7'b0010111,
    OPCODE_JAL      = 7'b1101111,
    OPCODE_JALR     = 7'b1100111,
    OPCODE_BRANCH   = 7'b1100011,
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_OP_IMM   = 7'b0010011,
    OPCODE_OP       = 7'b0110011,
    OPCODE_MISC_MEM = 7'b0001111,
    OPCODE_SYSTEM   = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_OR, ALU_AND,
    ALU_SEQ
  } alu_function_t;

  typedef enum logic [1:0] {
    WB_ALU, WB_MEMORY, WB_PC_PLUS_4, WB_IMMEDIATE
  } writeback_select_t;

  typedef enum logic [1:0] {
    NPC_PLUS_4, NPC_PLUS_IMMEDIATE, NPC_ALU, NPC_HOLD
  } next_pc_select_t;

  // Branch funct3 codes
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  localparam word_t INITIAL_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== logic/rv_ctrl_if.sv ====
// Decode fields up from the data path, control selects back down
// Purely combinational bundle, no clock

`default_nettype none

interface rv_ctrl_if;
  import rv_pkg::*;

  // Decoded fields and ALU flags
  opcode_t           inst_opcode;
  logic [2:0]        inst_funct3;
  logic [6:0]        inst_funct7;
  logic              alu_result_equal_zero;
  logic              alu_result_sign;

  // Selects and enables
  alu_function_t     alu_function;
  logic              alu_operand_a_select;
  logic              alu_operand_b_select;
  writeback_select_t reg_writeback_select;
  next_pc_select_t   next_pc_select;
  logic              regfile_write_enable;

  modport datapath (
    output inst_opcode, inst_funct3, inst_funct7,
    output alu_result_equal_zero, alu_result_sign,
    input  alu_function, alu_operand_a_select, alu_operand_b_select,
    input  reg_writeback_select, next_pc_select, regfile_write_enable
  );

  modport control (
    input  inst_opcode, inst_funct3, inst_funct7,
    input  alu_result_equal_zero, alu_result_sign,
    output alu_function, alu_operand_a_select, alu_operand_b_select,
    output reg_writeback_select, next_pc_select, regfile_write_enable
  );

endinterface

`default_nettype wire

// ==== logic/alu.sv ====
// 32-bit RV32I ALU, combinational
// Shift amount is the low five bits of operand_b

`default_nettype none

module alu (
  input  rv_pkg::alu_function_t alu_function,
  input  rv_pkg::word_t         operand_a,
  input  rv_pkg::word_t         operand_b,
  output rv_pkg::word_t         result,
  output logic                  result_equal_zero
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      ALU_ADD:  result = operand_a + operand_b;
      ALU_SUB:  result = operand_a - operand_b;
      // Equality tests look only at the zero flag
      ALU_SEQ:  result = operand_a - operand_b;
      ALU_SLL:  result = operand_a << shamt;
      ALU_SRL:  result = operand_a >> shamt;
      ALU_SRA:  result = word_t'($signed(operand_a) >>> shamt);
      ALU_SLT:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      ALU_SLTU: result = {31'b0, operand_a < operand_b};
      ALU_XOR:  result = operand_a ^ operand_b;
      ALU_OR:   result = operand_a | operand_b;
      ALU_AND:  result = operand_a & operand_b;
      default:  result = '0;
    endcase
  end

  assign result_equal_zero = (result == '0);

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
// 32 x 32 register file, two combinational reads, one write at the edge
// No reset on the registers, x0 always reads zero

`default_nettype none

module regfile (
  input  logic              clock,
  input  rv_pkg::reg_addr_t rs1_address,
  input  rv_pkg::reg_addr_t rs2_address,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              write_enable,
  input  rv_pkg::reg_addr_t rd_address,
  input  rv_pkg::word_t     rd_data
);
  import rv_pkg::*;

  word_t registers [32];

  always_ff @(posedge clock) begin
    if (write_enable && rd_address != '0) begin
      registers[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == '0) ? '0 : registers[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : registers[rs2_address];

endmodule

`default_nettype wire

// ==== logic/immediate_generator.sv ====
// Sign-extended immediate for the I, S, B, U and J formats
// Opcodes without an immediate give zero

`default_nettype none

module immediate_generator (
  input  rv_pkg::word_t inst,
  output rv_pkg::word_t immediate
);
  import rv_pkg::*;

  always_comb begin
    case (opcode_t'(inst[6:0]))
      // I-type
      OPCODE_JALR, OPCODE_LOAD, OPCODE_OP_IMM:
        immediate = {{20{inst[31]}}, inst[31:20]};
      // S-type
      OPCODE_STORE:
        immediate = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      // B-type, bit 0 is implied zero
      OPCODE_BRANCH:
        immediate = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      // U-type
      OPCODE_LUI, OPCODE_AUIPC:
        immediate = {inst[31:12], 12'b0};
      // J-type
      OPCODE_JAL:
        immediate = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/control_unit.sv ====
// Main decoder, branch decision and halt state
// ECALL and EBREAK halt until reset, the PC stays on the halting instruction
// Unknown opcodes, FENCE and CSR encodings retire as no-ops

`default_nettype none

module control_unit (
  input  logic          clock,
  input  logic          reset,
  rv_ctrl_if.control    ctrl,
  output logic          data_write_enable,
  output logic          data_read_enable,
  output logic          halted
);
  import rv_pkg::*;

  logic            active;
  logic            halt_request;
  logic            branch_taken;
  logic            decode_regfile_write;
  logic            decode_data_write;
  logic            decode_data_read;
  next_pc_select_t decode_next_pc;

  // funct3 to ALU operation, alt picks SUB or SRA
  function automatic alu_function_t op_function(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ------------------------------
  // Decode
  // ------------------------------
  always_comb begin
    ctrl.alu_function         = ALU_ADD;
    ctrl.alu_operand_a_select = 1'b0;
    ctrl.alu_operand_b_select = 1'b1;
    ctrl.reg_writeback_select = WB_ALU;
    decode_regfile_write      = 1'b0;
    decode_data_write         = 1'b0;
    decode_data_read          = 1'b0;
    decode_next_pc            = NPC_PLUS_4;
    halt_request              = 1'b0;
    branch_taken              = 1'b0;

    case (ctrl.inst_opcode)
      OPCODE_LUI: begin
        ctrl.reg_writeback_select = WB_IMMEDIATE;
        decode_regfile_write      = 1'b1;
      end
      OPCODE_AUIPC: begin
        ctrl.alu_operand_a_select = 1'b1;
        decode_regfile_write      = 1'b1;
      end
      OPCODE_JAL: begin
        ctrl.reg_writeback_select = WB_PC_PLUS_4;
        decode_regfile_write      = 1'b1;
        decode_next_pc            = NPC_PLUS_IMMEDIATE;
      end
      OPCODE_JALR: begin
        ctrl.reg_writeback_select = WB_PC_PLUS_4;
        decode_regfile_write      = 1'b1;
        decode_next_pc            = NPC_ALU;
      end
      OPCODE_BRANCH: begin
        ctrl.alu_operand_b_select = 1'b0;
        case (ctrl.inst_funct3)
          FUNCT3_BEQ: begin
            ctrl.alu_function = ALU_SEQ;
            branch_taken      = ctrl.alu_result_equal_zero;
          end
          FUNCT3_BNE: begin
            ctrl.alu_function = ALU_SEQ;
            branch_taken      = !ctrl.alu_result_equal_zero;
          end
          FUNCT3_BLT: begin
            ctrl.alu_function = ALU_SLT;
            branch_taken      = ctrl.alu_result_sign;
          end
          FUNCT3_BGE: begin
            ctrl.alu_function = ALU_SLT;
            branch_taken      = !ctrl.alu_result_sign;
          end
          FUNCT3_BLTU: begin
            ctrl.alu_function = ALU_SLTU;
            branch_taken      = ctrl.alu_result_sign;
          end
          FUNCT3_BGEU: begin
            ctrl.alu_function = ALU_SLTU;
            branch_taken      = !ctrl.alu_result_sign;
          end
          default: branch_taken = 1'b0;
        endcase
        if (branch_taken) begin
          decode_next_pc = NPC_PLUS_IMMEDIATE;
        end
      end
      // Word access only, width bits in funct3 are not checked
      OPCODE_LOAD: begin
        ctrl.reg_writeback_select = WB_MEMORY;
        decode_regfile_write      = 1'b1;
        decode_data_read          = 1'b1;
      end
      OPCODE_STORE: begin
        decode_data_write = 1'b1;
      end
      OPCODE_OP_IMM: begin
        ctrl.alu_function = op_function(ctrl.inst_funct3,
                                        ctrl.inst_funct7[5] && ctrl.inst_funct3 == 3'b101);
        decode_regfile_write = 1'b1;
      end
      OPCODE_OP: begin
        ctrl.alu_operand_b_select = 1'b0;
        ctrl.alu_function         = op_function(ctrl.inst_funct3, ctrl.inst_funct7[5]);
        decode_regfile_write      = 1'b1;
      end
      OPCODE_SYSTEM: begin
        // ECALL and EBREAK share funct3 zero
        if (ctrl.inst_funct3 == 3'b000) begin
          halt_request   = 1'b1;
          decode_next_pc = NPC_HOLD;
        end
      end
      default: ;
    endcase
  end

  // ------------------------------
  // Halt state and enables
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (halt_request) begin
      halted <= 1'b1;
    end
  end

  // Nothing commits in reset or once halted
  assign active = !reset && !halted;

  assign ctrl.regfile_write_enable = decode_regfile_write && active;
  assign data_write_enable         = decode_data_write && active;
  assign data_read_enable          = decode_data_read && active;
  assign ctrl.next_pc_select       = halted ? NPC_HOLD : decode_next_pc;

endmodule

`default_nettype wire

// ==== logic/singlecycle_datapath.sv ====
// Single-cycle data path: PC, register file, ALU and the writeback and next-PC muxes
// Memories are external and read combinationally in the same cycle

`default_nettype none

module singlecycle_datapath (
  input  logic          clock,
  input  logic          reset,
  input  rv_pkg::word_t inst,
  input  rv_pkg::word_t data_read_data,
  rv_ctrl_if.datapath   ctrl,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t data_address,
  output rv_pkg::word_t data_write_data
);
  import rv_pkg::*;

  word_t     pc_value;
  word_t     next_pc;
  word_t     pc_plus_4;
  word_t     pc_plus_immediate;
  word_t     immediate;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     operand_a;
  word_t     operand_b;
  word_t     alu_result;
  word_t     writeback_data;
  reg_addr_t inst_rd;
  reg_addr_t inst_rs1;
  reg_addr_t inst_rs2;

  // ------------------------------
  // Instruction fields
  // ------------------------------
  assign inst_rd  = inst[11:7];
  assign inst_rs1 = inst[19:15];
  assign inst_rs2 = inst[24:20];

  assign ctrl.inst_opcode = opcode_t'(inst[6:0]);
  assign ctrl.inst_funct3 = inst[14:12];
  assign ctrl.inst_funct7 = inst[31:25];

  immediate_generator igen (
    .inst      (inst),
    .immediate (immediate)
  );

  regfile regs (
    .clock        (clock),
    .rs1_address  (inst_rs1),
    .rs2_address  (inst_rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .write_enable (ctrl.regfile_write_enable),
    .rd_address   (inst_rd),
    .rd_data      (writeback_data)
  );

  // ------------------------------
  // Execute
  // ------------------------------
  assign operand_a = ctrl.alu_operand_a_select ? pc_value : rs1_data;
  assign operand_b = ctrl.alu_operand_b_select ? immediate : rs2_data;

  alu alu_core (
    .alu_function      (ctrl.alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (ctrl.alu_result_equal_zero)
  );

  // SLT and SLTU place the comparison in bit 0
  assign ctrl.alu_result_sign = alu_result[0];

  // ------------------------------
  // Writeback and next PC
  // ------------------------------
  assign pc_plus_4         = pc_value + 32'd4;
  assign pc_plus_immediate = pc_value + immediate;

  always_comb begin
    case (ctrl.reg_writeback_select)
      WB_ALU:       writeback_data = alu_result;
      WB_MEMORY:    writeback_data = data_read_data;
      WB_PC_PLUS_4: writeback_data = pc_plus_4;
      default:      writeback_data = immediate;
    endcase
  end

  always_comb begin
    case (ctrl.next_pc_select)
      NPC_PLUS_4:         next_pc = pc_plus_4;
      NPC_PLUS_IMMEDIATE: next_pc = pc_plus_immediate;
      NPC_ALU:            next_pc = {alu_result[31:1], 1'b0};
      default:            next_pc = pc_value;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_value <= INITIAL_PC;
    end else begin
      pc_value <= next_pc;
    end
  end

  assign pc              = pc_value;
  assign data_address    = alu_result;
  assign data_write_data = rs2_data;

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
// RV32I single-cycle core top level
// Instruction and data memories sit outside and must answer in the same cycle
// halted stays high after ECALL or EBREAK until the next reset

`default_nettype none

module rv_core (
  input  logic          clock,
  input  logic          reset,
  output rv_pkg::word_t inst_address,
  input  rv_pkg::word_t inst,
  output rv_pkg::word_t data_address,
  output rv_pkg::word_t data_write_data,
  output logic          data_write_enable,
  output logic          data_read_enable,
  input  rv_pkg::word_t data_read_data,
  output logic          halted
);

  rv_ctrl_if ctrl_bus ();

  control_unit control (
    .clock             (clock),
    .reset             (reset),
    .ctrl              (ctrl_bus.control),
    .data_write_enable (data_write_enable),
    .data_read_enable  (data_read_enable),
    .halted            (halted)
  );

  // Fetch address is the PC itself
  singlecycle_datapath datapath (
    .clock           (clock),
    .reset           (reset),
    .inst            (inst),
    .data_read_data  (data_read_data),
    .ctrl            (ctrl_bus.datapath),
    .pc              (inst_address),
    .data_address    (data_address),
    .data_write_data (data_write_data)
  );

endmodule

`default_nettype wire

// ==== dv/rv_iss.svh ====
// Reference RV32I model, included inside the testbench module
// Needs word_t and the opcodes from rv_pkg and MEM_WORDS declared before it
// Word loads and stores only, data addresses wrap at MEM_WORDS words

`ifndef RV_ISS_SVH
`define RV_ISS_SVH

word_t model_pc;
word_t model_regs [32];
word_t model_mem [MEM_WORDS];
logic  model_halted;

function automatic int word_index(input word_t address);
  return (address >> 2) % MEM_WORDS;
endfunction

// Register and immediate ALU operations by funct3
function automatic word_t op_result(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_cond(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// One instruction, returns the store it makes and updates the state
function automatic void step_model(input word_t ins, output logic st_en,
                                   output word_t st_addr, output word_t st_data);
  word_t rs1;
  word_t rs2;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;
  word_t rd_val;
  word_t next_pc;
  logic  wr;
  rs1     = model_regs[ins[19:15]];
  rs2     = model_regs[ins[24:20]];
  imm_i   = {{20{ins[31]}}, ins[31:20]};
  imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  wr      = 1'b0;
  rd_val  = '0;
  next_pc = model_pc + 32'd4;
  st_en   = 1'b0;
  st_addr = '0;
  st_data = '0;
  case (ins[6:0])
    OPCODE_LUI: begin
      wr     = 1'b1;
      rd_val = {ins[31:12], 12'b0};
    end
    OPCODE_AUIPC: begin
      wr     = 1'b1;
      rd_val = model_pc + {ins[31:12], 12'b0};
    end
    OPCODE_JAL: begin
      wr      = 1'b1;
      rd_val  = model_pc + 32'd4;
      next_pc = model_pc + imm_j;
    end
    OPCODE_JALR: begin
      wr      = 1'b1;
      rd_val  = model_pc + 32'd4;
      next_pc = (rs1 + imm_i) & ~32'd1;
    end
    OPCODE_BRANCH: begin
      if (branch_cond(ins[14:12], rs1, rs2)) begin
        next_pc = model_pc + imm_b;
      end
    end
    OPCODE_LOAD: begin
      wr     = 1'b1;
      rd_val = model_mem[word_index(rs1 + imm_i)];
    end
    OPCODE_STORE: begin
      st_en   = 1'b1;
      st_addr = rs1 + imm_s;
      st_data = rs2;
      model_mem[word_index(st_addr)] = rs2;
    end
    OPCODE_OP_IMM: begin
      wr     = 1'b1;
      rd_val = op_result(ins[14:12], ins[30] && ins[14:12] == 3'd5, rs1, imm_i);
    end
    OPCODE_OP: begin
      wr     = 1'b1;
      rd_val = op_result(ins[14:12], ins[30], rs1, rs2);
    end
    OPCODE_SYSTEM: begin
      if (ins[14:12] == 3'd0) begin
        next_pc      = model_pc;
        model_halted = 1'b1;
      end
    end
    default: ;
  endcase
  if (wr && ins[11:7] != 5'd0) begin
    model_regs[ins[11:7]] = rd_val;
  end
  model_pc = next_pc;
endfunction

`endif

// ==== dv/rv_core_tb.sv ====
// Testbench for the RV32I core with combinational instruction and data memories
// The same program runs twice, the second time after a reset from the halt state
// Register file has no reset, so the program sets every register it reads

`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam int MEM_WORDS  = 256;
  localparam int MAX_CYCLES = 1000;

  logic  clock;
  logic  reset;
  word_t inst_address;
  word_t inst;
  word_t data_address;
  word_t data_write_data;
  logic  data_write_enable;
  logic  data_read_enable;
  word_t data_read_data;
  logic  halted;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  int    prog_len;
  int    error_count;
  logic  exp_store;
  logic  exp_load;
  word_t exp_address;
  word_t exp_data;
  logic  reached_first;
  logic  reached_second;

  `include "rv_iss.svh"

  rv_core UUT (
    .clock             (clock),
    .reset             (reset),
    .inst_address      (inst_address),
    .inst              (inst),
    .data_address      (data_address),
    .data_write_data   (data_write_data),
    .data_write_enable (data_write_enable),
    .data_read_enable  (data_read_enable),
    .data_read_data    (data_read_data),
    .halted            (halted)
  );

  always #4 clock = ~clock;

  // ------------------------------
  // Memory models
  // ------------------------------
  assign inst           = imem[word_index(inst_address)];
  assign data_read_data = dmem[word_index(data_address)];

  always @(posedge clock) begin
    if (data_write_enable) begin
      dmem[word_index(data_address)] <= data_write_data;
    end
  end

  // ------------------------------
  // Instruction encoders
  // ------------------------------
  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic word_t i_type(input logic [6:0] op, input reg_addr_t rd,
                                   input logic [2:0] f3, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Always SW
  function automatic word_t s_type(input reg_addr_t rs2, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic word_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [6:0] op, input reg_addr_t rd,
                                   input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  function automatic logic [11:0] random_offset();
    return {$urandom % (MEM_WORDS - 1), 2'b00};
  endfunction

  task automatic emit(input word_t word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t expected);
    error_count++;
    $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
  endtask

  // ------------------------------
  // Program
  // ------------------------------
  task automatic build_program();
    int          branch_f3 [6] = '{0, 1, 4, 5, 6, 7};
    reg_addr_t   pair_a [3] = '{8, 9, 9};
    reg_addr_t   pair_b [3] = '{9, 8, 10};
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    prog_len = 0;
    for (int r = 1; r < 8; r++) begin
      emit(u_type(OPCODE_LUI, r, $urandom));
      emit(i_type(OPCODE_OP_IMM, r, 3'd0, r, $urandom));
    end
    // Upper immediates and a write to x0
    emit(u_type(OPCODE_LUI, 17, $urandom));
    emit(s_type(17, 0, random_offset()));
    emit(u_type(OPCODE_AUIPC, 18, $urandom));
    emit(s_type(18, 0, random_offset()));
    emit(i_type(OPCODE_OP_IMM, 0, 3'd0, 1, 12'h555));
    emit(s_type(0, 0, random_offset()));
    // Store, load back, store again
    imm = random_offset();
    emit(i_type(OPCODE_OP_IMM, 15, 3'd0, 0, $urandom));
    emit(s_type(15, 0, imm));
    emit(i_type(OPCODE_LOAD, 16, 3'b010, 0, imm));
    emit(s_type(16, 0, imm + 12'd4));
    // Branches over one store, x8 = -1, x9 = x10 = 1
    emit(i_type(OPCODE_OP_IMM, 8, 3'd0, 0, 12'hFFF));
    emit(i_type(OPCODE_OP_IMM, 9, 3'd0, 0, 12'd1));
    emit(i_type(OPCODE_OP_IMM, 10, 3'd0, 0, 12'd1));
    foreach (branch_f3[b]) begin
      for (int p = 0; p < 3; p++) begin
        emit(b_type(branch_f3[b], pair_a[p], pair_b[p], 13'd8));
        emit(s_type(9, 0, random_offset()));
      end
    end
    // JAL, then JALR to an odd target
    emit(j_type(12, 21'd8));
    emit(s_type(9, 0, random_offset()));
    emit(s_type(12, 0, random_offset()));
    emit(u_type(OPCODE_AUIPC, 13, 20'd0));
    emit(i_type(OPCODE_JALR, 14, 3'd0, 13, 12'd13));
    emit(s_type(9, 0, random_offset()));
    emit(s_type(14, 0, random_offset()));
    // Random block on x1 to x7
    for (int n = 0; n < 40; n++) begin
      rd  = 1 + $urandom % 7;
      rs1 = $urandom % 8;
      rs2 = $urandom % 8;
      f3  = $urandom;
      alt = (f3 == 3'd0 || f3 == 3'd5) ? $urandom % 2 : 1'b0;
      case ($urandom % 4)
        0: emit(r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd));
        1: begin
          if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {1'b0, alt && f3 == 3'd5, 5'b0, 5'($urandom)};
          end else begin
            imm = $urandom;
          end
          emit(i_type(OPCODE_OP_IMM, rd, f3, rs1, imm));
        end
        2: emit(i_type(OPCODE_LOAD, rd, 3'b010, 0, random_offset()));
        default: emit(s_type(rs2, 0, random_offset()));
      endcase
      emit(s_type(rd, 0, random_offset()));
    end
    emit(32'h0000_0073);
  endtask

  // Reset for two cycles, run to the halt, then watch it for 20 cycles
  task automatic run_program(output logic reached);
    @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    model_pc     = INITIAL_PC;
    model_halted = 1'b0;
    @(posedge clock);
    reset <= 1'b0;
    reached = 1'b0;
    for (int cycle = 0; cycle < MAX_CYCLES && !reached; cycle++) begin
      @(posedge clock);
      if (halted) begin
        reached = 1'b1;
      end
    end
    if (!reached) begin
      error_count++;
      $display("Program did not reach ECALL within %0d cycles", MAX_CYCLES);
    end else begin
      repeat (20) @(posedge clock);
    end
  endtask

  // ------------------------------
  // Compare against the model
  // ------------------------------
  always @(posedge clock) begin
    if (reset) begin
      if (data_write_enable !== 1'b0) begin
        report_mismatch("data_write_enable", data_write_enable, 0);
      end
      if (data_read_enable !== 1'b0) begin
        report_mismatch("data_read_enable", data_read_enable, 0);
      end
    end else if (model_halted) begin
      if (halted !== 1'b1) begin
        report_mismatch("halted", halted, 1);
      end
      if (inst_address !== model_pc) begin
        report_mismatch("inst_address", inst_address, model_pc);
      end
      if (data_write_enable !== 1'b0) begin
        report_mismatch("data_write_enable", data_write_enable, 0);
      end
      if (data_read_enable !== 1'b0) begin
        report_mismatch("data_read_enable", data_read_enable, 0);
      end
    end else begin
      if (halted !== 1'b0) begin
        report_mismatch("halted", halted, 0);
      end
      if (inst_address !== model_pc) begin
        report_mismatch("inst_address", inst_address, model_pc);
      end
      // Only LW reads data memory
      exp_load = (imem[word_index(model_pc)][6:0] == OPCODE_LOAD);
      step_model(imem[word_index(model_pc)], exp_store, exp_address, exp_data);
      if (data_write_enable !== exp_store) begin
        report_mismatch("data_write_enable", data_write_enable, exp_store);
      end
      if (data_read_enable !== exp_load) begin
        report_mismatch("data_read_enable", data_read_enable, exp_load);
      end
      if (exp_store && data_address !== exp_address) begin
        report_mismatch("data_address", data_address, exp_address);
      end
      if (exp_store && data_write_data !== exp_data) begin
        report_mismatch("data_write_data", data_write_data, exp_data);
      end
    end
  end

  initial begin
    void'($urandom(32'h785));
    clock        = 1'b0;
    reset        = 1'b1;
    error_count  = 0;
    model_pc     = INITIAL_PC;
    model_halted = 1'b0;
    reached_second = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i]       = i_type(OPCODE_OP_IMM, 0, 3'd0, 0, i);
      dmem[i]       = 32'h9E37_79B9 * (i + 1);
      model_mem[i]  = dmem[i];
    end
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    build_program();
    run_program(reached_first);
    if (reached_first) begin
      run_program(reached_second);
    end
    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0 && reached_second) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+dv
logic/rv_pkg.sv
logic/rv_ctrl_if.sv
logic/alu.sv
logic/regfile.sv
logic/immediate_generator.sv
logic/control_unit.sv
logic/singlecycle_datapath.sv
logic/rv_core.sv
dv/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_ctrl_if.sv
  - logic/alu.sv
  - logic/regfile.sv
  - logic/immediate_generator.sv
  - logic/control_unit.sv
  - logic/singlecycle_datapath.sv
  - logic/rv_core.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv
